/* sources.f */
src/control_unit_pkg.sv
src/opcode_decoder.sv
src/control_sequencer.sv
src/control_outputs.sv
src/control_unit.sv
verification/control_unit_tb.sv

/* Makefile */
# Verilator flow for the multicycle control unit
VERILATOR ?= verilator
TOP       ?= control_unit_tb
RTL_TOP   ?= control_unit
FILELIST  ?= sources.f
BUILD_DIR ?= build
SIM_FLAGS ?=
PASS_MSG  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-f $(FILELIST) $(SIM_FLAGS)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/control_unit_input.txt */
# instr (hex), eq, lt, expected state (hex), expected control word (hex)
# One line per clock, applied on the falling edge and checked on the next one
00000000 0 0 00 80000
00000000 0 0 00 80000
00000000 0 0 00 80000
002081B3 0 0 01 18000
002081B3 0 0 02 40809
002081B3 0 0 03 03000
002081B3 0 0 04 00841
002081B3 0 0 09 00200
402081B3 1 0 01 18000
402081B3 1 0 02 40809
402081B3 1 0 03 03000
402081B3 1 0 04 00842
402081B3 1 0 09 00200
00508193 0 0 01 18000
00508193 0 0 02 40809
00508193 0 0 03 03000
00508193 0 0 07 00851
00508193 0 0 09 00200
123451B7 0 1 01 18000
123451B7 0 1 02 40809
123451B7 0 1 03 03000
123451B7 0 1 08 00891
123451B7 0 1 09 00200
0020A1B3 0 1 01 18000
0020A1B3 0 1 02 40809
0020A1B3 0 1 03 03000
0020A1B3 0 1 05 00042
0020A1B3 0 1 06 008E1
0020A1B3 0 1 09 00200
0050A193 0 0 01 18000
0050A193 0 0 02 40809
0050A193 0 0 03 03000
0050A193 0 0 05 00052
0050A193 0 0 06 008A1
0050A193 0 0 09 00200
0080B183 0 0 01 18000
0080B183 0 0 02 40809
0080B183 0 0 03 03000
0080B183 0 0 0A 00851
0080B183 0 0 0B 08000
0080B183 0 0 0C 00400
0080B183 0 0 0D 00300
0020F423 0 0 01 18000
0020F423 0 0 02 40809
0020F423 0 0 03 03000
0020F423 0 0 0E 00851
0020F423 0 0 0F 04000
0020F423 0 0 10 00000
00208463 1 0 01 18000
00208463 1 0 02 40809
00208463 1 0 03 03000
00208463 1 0 11 00819
00208463 1 0 12 60000
00208463 0 1 01 18000
00208463 0 1 02 40809
00208463 0 1 03 03000
00208463 0 1 11 00819
00208463 0 1 12 00000
00209467 0 0 01 18000
00209467 0 0 02 40809
00209467 0 0 03 03000
00209467 0 0 11 00819
00209467 0 0 12 60000
00209467 1 0 01 18000
00209467 1 0 02 40809
00209467 1 0 03 03000
00209467 1 0 11 00819
00209467 1 0 12 00000
0020C467 0 1 01 18000
0020C467 0 1 02 40809
0020C467 0 1 03 03000
0020C467 0 1 11 00819
0020C467 0 1 12 60000
0020C467 1 0 01 18000
0020C467 1 0 02 40809
0020C467 1 0 03 03000
0020C467 1 0 11 00819
0020C467 1 0 12 00000
0020D467 0 0 01 18000
0020D467 0 0 02 40809
0020D467 0 0 03 03000
0020D467 0 0 11 00819
0020D467 0 0 12 60000
0020D467 0 1 01 18000
0020D467 0 1 02 40809
0020D467 0 1 03 03000
0020D467 0 1 11 00819
0020D467 0 1 12 00000
000280E7 0 0 01 18000
000280E7 0 0 02 40809
000280E7 0 0 03 03000
000280E7 0 0 13 00821
000280E7 0 0 14 00200
000280E7 0 0 15 40051
008000EF 0 0 01 18000
008000EF 0 0 02 40809
008000EF 0 0 03 03000
002081B3 0 0 01 18000

/* verification/control_unit_tb.sv */
`timescale 1ns/1ns

module control_unit_tb;
   import control_unit_pkg::*;

   localparam string INPUT_FILE = "verification/control_unit_input.txt";

   logic       CLK;
   logic       RESET;
   instr_t     instr;
   cmp_flags_t flags;
   ctrl_t      ctrl;
   state_t     state;

   int cycle_count = 0;
   int cycle_limit = 0;                       // Zero until the input file is counted
   int line_no     = 0;                       // Last line read from the file

   control_unit dut
   (
      .CLK   (CLK),
      .RESET (RESET),
      .instr (instr),
      .flags (flags),
      .ctrl  (ctrl),
      .state (state)
   );

   initial
   begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   initial
   begin
      RESET = 1'b1;
      repeat (3) @(posedge CLK);
      @(negedge CLK);
      RESET = 1'b0;                           // First fetch on the next rising edge
   end

   always @(posedge CLK)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
      begin
         $display("Timeout: the run did not end within %0d cycles", cycle_limit);
         $display("Done: errors found");
         $fatal(1, "timeout");
      end
   end

   task automatic stop_unless_open(input int fd);
      if (fd == 0)
      begin
         $display("Cannot open the input file %s", INPUT_FILE);
         $display("Done: errors found");
         $fatal(1, "input file missing");
      end
   endtask

   // Next test line of the file
   task automatic read_record(input int fd, output bit found, output instr_t instr_v,
                              output cmp_flags_t flags_v, output state_t state_v,
                              output ctrl_t ctrl_v);
      string                    text;
      int                       eq_v;
      int                       lt_v;
      logic [4:0]               state_bits;
      logic [$bits(ctrl_t)-1:0] ctrl_bits;
      found   = 1'b0;
      instr_v = '0;
      flags_v = '0;
      state_v = st_reset;
      ctrl_v  = CTRL_IDLE;
      while (!found && !$feof(fd))
      begin
         text = "";
         void'($fgets(text, fd));
         line_no = line_no + 1;
         if (text.len() > 1 && text[0] != "#")   // Skip comments and blank lines
         begin
            if ($sscanf(text, "%h %d %d %h %h", instr_v, eq_v, lt_v, state_bits,
                        ctrl_bits) != 5)
            begin
               $display("Line %0d of %s is not a valid test line", line_no, INPUT_FILE);
               $display("Done: errors found");
               $fatal(1, "bad input line");
            end
            else
            begin
               flags_v.eq = eq_v[0];
               flags_v.lt = lt_v[0];
               state_v    = state_t'(state_bits);
               ctrl_v     = ctrl_t'(ctrl_bits);
               found      = 1'b1;
            end
         end
      end
   endtask

   task automatic check_state(input string name, input state_t expected, input state_t actual);
      if (actual !== expected)
      begin
         $display("** Error %s: state expected %s (%h), actual %s (%h)", name,
                  expected.name(), expected, actual.name(), actual);
         $display("Done: errors found");
         $fatal(1, "state mismatch");
      end
   endtask

   task automatic check_ctrl(input string name, input ctrl_t expected, input ctrl_t actual);
      if (actual !== expected)
      begin
         $display("** Error %s: control word expected %h, actual %h", name, expected, actual);
         $display("Done: errors found");
         $fatal(1, "control word mismatch");
      end
   endtask

   initial
   begin
      int         fd;
      int         records;
      bit         found;
      instr_t     instr_v;
      cmp_flags_t flags_v;
      state_t     state_v;
      ctrl_t      ctrl_v;
      string      name;

      instr   = '0;
      flags   = '0;
      records = 0;
      found   = 1'b1;
      fd = $fopen(INPUT_FILE, "r");
      stop_unless_open(fd);
      while (found)                           // Count pass sets the timeout
      begin
         read_record(fd, found, instr_v, flags_v, state_v, ctrl_v);
         if (found)
            records = records + 1;
      end
      $fclose(fd);
      cycle_limit = records + 20;
      if (records == 0)
      begin
         $display("The input file %s holds no test lines", INPUT_FILE);
         $display("Done: errors found");
         $fatal(1, "empty input file");
      end

      line_no = 0;
      fd = $fopen(INPUT_FILE, "r");
      stop_unless_open(fd);
      read_record(fd, found, instr_v, flags_v, state_v, ctrl_v);
      flags = flags_v;
      while (found)
      begin
         @(negedge CLK);                      // Rising edge has settled by now
         name = $sformatf("line %0d, instr %h", line_no, instr_v);
         check_state(name, state_v, state);
         check_ctrl(name, ctrl_v, ctrl);
         instr = instr_v;                     // Held through the edge that leaves this state
         read_record(fd, found, instr_v, flags_v, state_v, ctrl_v);
         if (found)
            flags = flags_v;
      end
      $fclose(fd);
      $display("Done: no errors");
      $finish;
   end

endmodule

/* src/control_unit.sv */
`timescale 1ns/1ns

module control_unit
(
   input  logic                         CLK,
   input  logic                         RESET,
   input  control_unit_pkg::instr_t     instr,
   input  control_unit_pkg::cmp_flags_t flags,
   output control_unit_pkg::ctrl_t      ctrl,
   output control_unit_pkg::state_t     state
);
   import control_unit_pkg::*;

   instr_class_t instr_class;

   // Combinational, follows the held instruction register
   opcode_decoder u_decoder
   (
      .instr       (instr),
      .instr_class (instr_class)
   );

   control_sequencer u_sequencer
   (
      .CLK         (CLK),
      .RESET       (RESET),
      .instr_class (instr_class),
      .state       (state)
   );

   control_outputs u_outputs
   (
      .state       (state),
      .instr_class (instr_class),
      .flags       (flags),
      .ctrl        (ctrl)
   );

endmodule

/* src/control_outputs.sv */
`timescale 1ns/1ns

module control_outputs
(
   input  control_unit_pkg::state_t       state,
   input  control_unit_pkg::instr_class_t instr_class,
   input  control_unit_pkg::cmp_flags_t   flags,
   output control_unit_pkg::ctrl_t        ctrl
);
   import control_unit_pkg::*;

   logic branch_taken;

   always_comb
   begin
      case (instr_class)
         cls_beq: branch_taken = flags.eq;
         cls_bne: branch_taken = !flags.eq;
         cls_blt: branch_taken = flags.lt;
         cls_bge: branch_taken = !flags.lt;
         default: branch_taken = 1'b0;
      endcase
   end

   always_comb
   begin
      ctrl = CTRL_IDLE;
      case (state)
         st_reset:
            ctrl.datapath_reset = 1'b1;
         st_fetch:
         begin
            ctrl.mem_read = 1'b1;
            ctrl.ir_load  = 1'b1;
         end
         st_pc_incr:
         begin
            ctrl.alu_src_a    = src_a_pc;     // PC + 4
            ctrl.alu_src_b    = src_b_four;
            ctrl.alu_op       = alu_add;
            ctrl.alu_out_load = 1'b1;
            ctrl.pc_write     = 1'b1;
         end
         st_decode:
         begin
            ctrl.a_load = 1'b1;
            ctrl.b_load = 1'b1;
         end
         st_r_exec:
         begin
            ctrl.alu_src_a    = src_a_reg_a;
            ctrl.alu_src_b    = src_b_reg_b;
            ctrl.alu_op       = (instr_class == cls_sub) ? alu_sub : alu_add;
            ctrl.alu_out_load = 1'b1;
         end
         st_slt_compare:
         begin
            ctrl.alu_src_a = src_a_reg_a;     // Subtract so the datapath sets lt
            ctrl.alu_src_b = (instr_class == cls_slti) ? src_b_imm : src_b_reg_b;
            ctrl.alu_op    = alu_sub;
         end
         st_slt_set:
         begin
            ctrl.alu_src_a    = flags.lt ? src_a_one : src_a_zero;  // 1 + 0 or 0 + 0
            ctrl.alu_src_b    = src_b_zero;
            ctrl.alu_op       = alu_add;
            ctrl.alu_out_load = 1'b1;
         end
         st_imm_exec, st_load_addr, st_store_addr:
         begin
            ctrl.alu_src_a    = src_a_reg_a;  // rs1 + imm
            ctrl.alu_src_b    = src_b_imm;
            ctrl.alu_op       = alu_add;
            ctrl.alu_out_load = 1'b1;
         end
         st_lui_exec:
         begin
            ctrl.alu_src_a    = src_a_zero;
            ctrl.alu_src_b    = src_b_imm;
            ctrl.alu_op       = alu_add;
            ctrl.alu_out_load = 1'b1;
         end
         st_write_back, st_jalr_write:
            ctrl.reg_write = 1'b1;
         st_load_wait:
            ctrl.mem_read = 1'b1;
         st_load_capture:
            ctrl.mdr_load = 1'b1;
         st_load_write:
         begin
            ctrl.reg_write   = 1'b1;
            ctrl.wb_from_mdr = 1'b1;
         end
         st_store_write:
            ctrl.mem_write = 1'b1;
         st_branch_target:
         begin
            ctrl.alu_src_a    = src_a_pc;     // Target held in ALU out until resolve
            ctrl.alu_src_b    = src_b_branch_imm;
            ctrl.alu_op       = alu_add;
            ctrl.alu_out_load = 1'b1;
         end
         st_branch_resolve:
         begin
            ctrl.pc_write       = branch_taken;
            ctrl.pc_src_alu_out = branch_taken;
         end
         st_jalr_link:
         begin
            ctrl.alu_src_a    = src_a_pc;     // Return address, PC already advanced
            ctrl.alu_src_b    = src_b_zero;
            ctrl.alu_op       = alu_add;
            ctrl.alu_out_load = 1'b1;
         end
         st_jalr_jump:
         begin
            ctrl.alu_src_a = src_a_reg_a;
            ctrl.alu_src_b = src_b_imm;
            ctrl.alu_op    = alu_add;
            ctrl.pc_write  = 1'b1;            // PC takes the ALU result directly
         end
         default:
            ctrl = CTRL_IDLE;                 // st_store_done and anything else
      endcase
   end

   // Sampled on each state change, so every state's settled word is checked
   mem_exclusive: assert property (
      @(state) !(ctrl.mem_read && ctrl.mem_write)
   );

   pc_src_needs_write: assert property (
      @(state) ctrl.pc_src_alu_out |-> ctrl.pc_write
   );

endmodule

/* src/control_sequencer.sv */
`timescale 1ns/1ns

module control_sequencer
(
   input  logic                           CLK,
   input  logic                           RESET,
   input  control_unit_pkg::instr_class_t instr_class,
   output control_unit_pkg::state_t       state
);
   import control_unit_pkg::*;

   state_t next_state;

   always_ff @(posedge CLK, posedge RESET)
   begin
      if (RESET)
      begin
         state <= st_reset;
      end
      else
      begin
         state <= next_state;
      end
   end

   always_comb
   begin
      next_state = st_fetch;
      case (state)
         st_reset:          next_state = st_fetch;
         st_fetch:          next_state = st_pc_incr;
         st_pc_incr:        next_state = st_decode;

         // Only decision point of the sequence
         st_decode:
         begin
            case (instr_class)
               cls_add, cls_sub:   next_state = st_r_exec;
               cls_slt, cls_slti:  next_state = st_slt_compare;
               cls_addi:           next_state = st_imm_exec;
               cls_lui:            next_state = st_lui_exec;
               cls_load:           next_state = st_load_addr;
               cls_store:          next_state = st_store_addr;
               cls_beq, cls_bne,
               cls_blt, cls_bge:   next_state = st_branch_target;
               cls_jalr:           next_state = st_jalr_link;
               default:            next_state = st_fetch;   // Unsupported opcode
            endcase
         end

         st_r_exec:         next_state = st_write_back;
         st_slt_compare:    next_state = st_slt_set;
         st_slt_set:        next_state = st_write_back;  // Result picked by flags, not path
         st_imm_exec:       next_state = st_write_back;
         st_lui_exec:       next_state = st_write_back;

         st_load_addr:      next_state = st_load_wait;
         st_load_wait:      next_state = st_load_capture;
         st_load_capture:   next_state = st_load_write;

         st_store_addr:     next_state = st_store_write;
         st_store_write:    next_state = st_store_done;

         st_branch_target:  next_state = st_branch_resolve;

         st_jalr_link:      next_state = st_jalr_write;
         st_jalr_write:     next_state = st_jalr_jump;

         // Final states of every instruction
         st_write_back,
         st_load_write,
         st_store_done,
         st_branch_resolve,
         st_jalr_jump:      next_state = st_fetch;

         default:           next_state = st_fetch;
      endcase
   end

   // Decode always hands off to some other state
   decode_leaves: assert property (
      @(posedge CLK) disable iff (RESET)
      state == st_decode |=> state != st_decode
   );

   // Longest instruction is ld, seven cycles from fetch to fetch
   fetch_returns: assert property (
      @(posedge CLK) disable iff (RESET)
      state == st_fetch |-> ##[1:7] state == st_fetch
   );

endmodule

/* src/opcode_decoder.sv */
`timescale 1ns/1ns

module opcode_decoder
(
   input  control_unit_pkg::instr_t       instr,
   output control_unit_pkg::instr_class_t instr_class
);
   import control_unit_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   always_comb
   begin
      instr_class = cls_unsupported;          // Anything not matched below
      case (opcode)
         OPC_R_TYPE:
         begin
            if (funct3 == F3_ADD_SUB && funct7 == F7_ADD)
               instr_class = cls_add;
            else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB)
               instr_class = cls_sub;
            else if (funct3 == F3_SLT && funct7 == F7_ADD)
               instr_class = cls_slt;
         end
         OPC_IMM:
         begin
            if (funct3 == F3_ADD_SUB)
               instr_class = cls_addi;
            else if (funct3 == F3_SLT)
               instr_class = cls_slti;        // Shift encodings fall through
         end
         OPC_LOAD:
         begin
            if (funct3 == F3_LD)
               instr_class = cls_load;
         end
         OPC_STORE:
         begin
            if (funct3 == F3_SD)
               instr_class = cls_store;
         end
         OPC_BEQ:
            instr_class = cls_beq;
         OPC_BRANCH_JALR:
         begin
            case (funct3)
               F3_JALR: instr_class = cls_jalr;
               F3_BNE:  instr_class = cls_bne;
               F3_BLT:  instr_class = cls_blt;
               F3_BGE:  instr_class = cls_bge;
               default: instr_class = cls_unsupported;
            endcase
         end
         OPC_LUI:
            instr_class = cls_lui;
         default:
            instr_class = cls_unsupported;
      endcase
   end

endmodule

/* src/control_unit_pkg.sv */
package control_unit_pkg;

   typedef logic [31:0] instr_t;              // Raw instruction register contents

   typedef struct packed
   {
      logic eq;                               // Operands equal
      logic lt;                               // Operand A less than B, signed
   } cmp_flags_t;

   typedef enum logic [3:0]
   {
      cls_add, cls_sub, cls_slt,
      cls_addi, cls_slti, cls_lui,
      cls_load, cls_store,
      cls_beq, cls_bne, cls_blt, cls_bge,
      cls_jalr,
      cls_unsupported
   } instr_class_t;

   typedef enum logic [4:0]
   {
      st_reset, st_fetch, st_pc_incr, st_decode,
      st_r_exec, st_slt_compare, st_slt_set, st_imm_exec, st_lui_exec, st_write_back,
      st_load_addr, st_load_wait, st_load_capture, st_load_write,
      st_store_addr, st_store_write, st_store_done,
      st_branch_target, st_branch_resolve,
      st_jalr_link, st_jalr_write, st_jalr_jump
   } state_t;

   typedef enum logic [1:0] {src_a_pc, src_a_reg_a, src_a_zero, src_a_one} alu_src_a_t;

   typedef enum logic [2:0]
   {
      src_b_reg_b, src_b_four, src_b_imm, src_b_branch_imm, src_b_zero
   } alu_src_b_t;

   typedef enum logic [2:0] {alu_pass, alu_add, alu_sub} alu_op_t;

   typedef struct packed
   {
      logic       datapath_reset;
      logic       pc_write;
      logic       pc_src_alu_out;             // PC loads from ALU out instead of ALU result
      logic       ir_load;
      logic       mem_read;
      logic       mem_write;
      logic       a_load;
      logic       b_load;
      logic       alu_out_load;
      logic       mdr_load;
      logic       reg_write;
      logic       wb_from_mdr;                // Write back data from MDR, else ALU out
      alu_src_a_t alu_src_a;
      alu_src_b_t alu_src_b;
      alu_op_t    alu_op;
   } ctrl_t;

   localparam ctrl_t CTRL_IDLE = '0;

   // Opcodes, modified encoding: branches other than beq share the jalr opcode
   localparam logic [6:0] OPC_R_TYPE      = 7'd51;
   localparam logic [6:0] OPC_IMM         = 7'd19;
   localparam logic [6:0] OPC_LOAD        = 7'd3;
   localparam logic [6:0] OPC_STORE       = 7'd35;
   localparam logic [6:0] OPC_BEQ         = 7'd99;
   localparam logic [6:0] OPC_BRANCH_JALR = 7'd103;
   localparam logic [6:0] OPC_LUI         = 7'd55;

   localparam logic [2:0] F3_ADD_SUB = 3'd0;
   localparam logic [2:0] F3_SLT     = 3'd2;
   localparam logic [2:0] F3_LD      = 3'd3;
   localparam logic [2:0] F3_SD      = 3'd7;
   localparam logic [2:0] F3_BNE     = 3'd1;
   localparam logic [2:0] F3_BLT     = 3'd4;
   localparam logic [2:0] F3_BGE     = 3'd5;
   localparam logic [2:0] F3_JALR    = 3'd0;

   localparam logic [6:0] F7_ADD = 7'd0;
   localparam logic [6:0] F7_SUB = 7'd32;

endpackage
